/* rtl/uart_cmd_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_bridge
  import uart_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  // Wishbone classic slave
  input  logic                    wb_cyc,
  input  logic                    wb_stb,
  input  logic                    wb_we,
  input  logic [wb_adr_width-1:0] wb_adr,
  input  logic [wb_dat_width-1:0] wb_dat_i,
  output logic [wb_dat_width-1:0] wb_dat_o,
  output logic                    wb_ack,
  // Serial lines
  output logic                    tx,
  input  logic                    rx
);

  logic [cmd_width-1:0] cmd_data;
  logic                 cmd_valid;
  logic                 cmd_ready;
  logic                 tx_busy;

  uart_rx_if rx_link ();

  uart_wb_regs u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_i  (wb_dat_i),
    .wb_dat_o  (wb_dat_o),
    .wb_ack    (wb_ack),
    .cmd_data  (cmd_data),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .busy      (tx_busy),
    .rx_if     (rx_link.sink)
  );

  uart_tx u_tx (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_data  (cmd_data),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .busy      (tx_busy),
    .tx        (tx)
  );

  // rx is synchronized inside the receiver
  uart_rx u_rx (
    .clk   (clk),
    .rst_n (rst_n),
    .rx    (rx),
    .rx_if (rx_link.source)
  );

endmodule

`default_nettype wire

/* rtl/uart_pkg.sv */
`default_nettype none

package uart_pkg;

  // ====================
  // Serial timing
  // ====================
  // 50 MHz clock at 115200 baud
  localparam int clks_per_bit   = 434;
  localparam int half_bit       = clks_per_bit / 2;
  localparam int baud_cnt_width = $clog2(clks_per_bit);
  localparam int byte_width     = 8;
  localparam int bit_cnt_width  = $clog2(byte_width);
  localparam bit check_parity   = 1'b1;

  // ====================
  // Bus and registers
  // ====================
  localparam int cmd_width    = 16;
  localparam int wb_adr_width = 2;
  localparam int wb_dat_width = 16;

  // Status word bit positions
  localparam int st_tx_busy    = 0;
  localparam int st_rx_valid   = 1;
  localparam int st_parity_err = 2;
  localparam int st_frame_err  = 3;
  localparam int st_overrun    = 4;

  typedef enum logic [wb_adr_width-1:0] {
    reg_cmd    = 0,
    reg_status = 1,
    reg_rxdata = 2
  } reg_addr_e;

  typedef enum logic [2:0] {
    tx_idle, tx_start, tx_data, tx_parity, tx_stop
  } tx_state_e;

  typedef enum logic [2:0] {
    rx_idle, rx_start, rx_data, rx_parity, rx_stop
  } rx_state_e;

endpackage

`default_nettype wire

/* rtl/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx
  import uart_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     rx,
  uart_rx_if.source rx_if
);

  rx_state_e                 state;
  logic                      rx_meta;
  logic                      rx_sync;
  logic                      rx_prev;
  logic                      fall;
  logic [baud_cnt_width-1:0] baud_cnt;
  logic [bit_cnt_width-1:0]  bit_cnt;
  logic                      half_done;
  logic                      full_done;
  logic [byte_width-1:0]     shift_q;
  logic                      parity_q;

  // ====================
  // Input synchronizer
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign fall      = rx_prev && !rx_sync;
  assign half_done = (baud_cnt == baud_cnt_width'(half_bit - 1));
  assign full_done = (baud_cnt == baud_cnt_width'(clks_per_bit - 1));

  // Restarts at the start edge, at mid start bit and at every sample
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      baud_cnt <= '0;
    end else if (state == rx_idle || full_done || (state == rx_start && half_done)) begin
      baud_cnt <= '0;
    end else begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  // ====================
  // Deframing FSM
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state            <= rx_idle;
      bit_cnt          <= '0;
      rx_if.done       <= 1'b0;
      rx_if.parity_err <= 1'b0;
      rx_if.frame_err  <= 1'b0;
    end else begin
      rx_if.done <= 1'b0;
      case (state)
        rx_idle: begin
          if (fall) begin
            state <= rx_start;
          end
        end
        rx_start: begin
          if (half_done) begin
            // Line back high means a glitch
            state   <= rx_sync ? rx_idle : rx_data;
            bit_cnt <= '0;
          end
        end
        rx_data: begin
          if (full_done) begin
            if (bit_cnt == bit_cnt_width'(byte_width - 1)) begin
              state <= rx_parity;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
        rx_parity: begin
          if (full_done) begin
            state <= rx_stop;
          end
        end
        rx_stop: begin
          if (full_done) begin
            state            <= rx_idle;
            rx_if.done       <= 1'b1;
            rx_if.parity_err <= check_parity && !(^{shift_q, parity_q});
            rx_if.frame_err  <= !rx_sync;
          end
        end
        default: state <= rx_idle;
      endcase
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk) begin
    if (state == rx_data && full_done) begin
      shift_q <= {rx_sync, shift_q[byte_width-1:1]};
    end
    if (state == rx_parity && full_done) begin
      parity_q <= rx_sync;
    end
    if (state == rx_stop && full_done) begin
      rx_if.data <= shift_q;
    end
  end

endmodule

`default_nettype wire

/* rtl/uart_rx_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface uart_rx_if import uart_pkg::*; ();

  logic [byte_width-1:0] data;
  logic                  parity_err;
  logic                  frame_err;
  // One cycle per received frame
  logic                  done;

  modport source (
    output data, parity_err, frame_err, done
  );

  modport sink (
    input data, parity_err, frame_err, done
  );

endinterface

`default_nettype wire

/* rtl/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx
  import uart_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [cmd_width-1:0] cmd_data,
  input  logic                 cmd_valid,
  output logic                 cmd_ready,
  output logic                 busy,
  output logic                 tx
);

  tx_state_e                  state;
  logic [cmd_width-1:0]       cmd_q;
  logic                       hi_sel;
  logic [baud_cnt_width-1:0]  baud_cnt;
  logic [bit_cnt_width-1:0]   bit_cnt;
  logic                       baud_done;
  logic [byte_width-1:0]      cur_byte;
  logic                       parity_bit;

  assign cmd_ready = (state == tx_idle);
  assign busy      = (state != tx_idle);

  // High byte goes out first
  assign cur_byte   = hi_sel ? cmd_q[cmd_width-1 -: byte_width] : cmd_q[byte_width-1:0];
  assign parity_bit = ~^cur_byte;

  assign baud_done = (baud_cnt == baud_cnt_width'(clks_per_bit - 1));

  // ====================
  // Baud counter
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      baud_cnt <= '0;
    end else if (state == tx_idle || baud_done) begin
      baud_cnt <= '0;
    end else begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  // Command latch
  always_ff @(posedge clk) begin
    if (cmd_valid && cmd_ready) begin
      cmd_q <= cmd_data;
    end
  end

  // ====================
  // Frame FSM
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= tx_idle;
      hi_sel  <= 1'b0;
      bit_cnt <= '0;
      tx      <= 1'b1;
    end else begin
      case (state)
        tx_idle: begin
          tx <= 1'b1;
          if (cmd_valid) begin
            state  <= tx_start;
            hi_sel <= 1'b1;
            tx     <= 1'b0;
          end
        end
        tx_start: begin
          if (baud_done) begin
            state   <= tx_data;
            bit_cnt <= '0;
            tx      <= cur_byte[0];
          end
        end
        tx_data: begin
          if (baud_done) begin
            if (bit_cnt == bit_cnt_width'(byte_width - 1)) begin
              state <= tx_parity;
              tx    <= parity_bit;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
              tx      <= cur_byte[bit_cnt + 1'b1];
            end
          end
        end
        tx_parity: begin
          if (baud_done) begin
            state <= tx_stop;
            tx    <= 1'b1;
          end
        end
        tx_stop: begin
          if (baud_done) begin
            // Low frame follows with no gap
            if (hi_sel) begin
              hi_sel <= 1'b0;
              state  <= tx_start;
              tx     <= 1'b0;
            end else begin
              state <= tx_idle;
            end
          end
        end
        default: begin
          state <= tx_idle;
          tx    <= 1'b1;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/uart_wb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_wb_regs
  import uart_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    wb_cyc,
  input  logic                    wb_stb,
  input  logic                    wb_we,
  input  logic [wb_adr_width-1:0] wb_adr,
  input  logic [wb_dat_width-1:0] wb_dat_i,
  output logic [wb_dat_width-1:0] wb_dat_o,
  output logic                    wb_ack,
  output logic [cmd_width-1:0]    cmd_data,
  output logic                    cmd_valid,
  input  logic                    cmd_ready,
  input  logic                    busy,
  uart_rx_if.sink                 rx_if
);

  reg_addr_e               addr;
  logic                    wb_req;
  logic                    cmd_wr;
  logic                    cmd_fire;
  logic                    plain_acc;
  logic                    status_wr;
  logic                    rxdata_rd;
  logic [byte_width-1:0]   rx_byte;
  logic                    rx_valid;
  logic                    parity_err;
  logic                    frame_err;
  logic                    overrun;
  logic [wb_dat_width-1:0] status;

  assign addr   = reg_addr_e'(wb_adr);
  // Low while ack is out so one access gives one ack
  assign wb_req = wb_cyc && wb_stb && !wb_ack;

  assign cmd_wr    = wb_req && wb_we && (addr == reg_cmd);
  assign cmd_fire  = cmd_valid && cmd_ready;
  assign plain_acc = wb_req && !(wb_we && addr == reg_cmd);
  assign status_wr = plain_acc && wb_we && (addr == reg_status);
  assign rxdata_rd = plain_acc && !wb_we && (addr == reg_rxdata);

  always_comb begin
    status                = '0;
    status[st_tx_busy]    = busy;
    status[st_rx_valid]   = rx_valid;
    status[st_parity_err] = parity_err;
    status[st_frame_err]  = frame_err;
    status[st_overrun]    = overrun;
  end

  // ====================
  // Bus handshake
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cmd_valid <= 1'b0;
      wb_ack    <= 1'b0;
      wb_dat_o  <= '0;
    end else begin
      // Command ack waits for the transmitter
      wb_ack <= cmd_fire || plain_acc;
      if (cmd_fire) begin
        cmd_valid <= 1'b0;
      end else if (cmd_wr) begin
        cmd_valid <= 1'b1;
      end
      if (plain_acc && !wb_we) begin
        case (addr)
          reg_status: wb_dat_o <= status;
          reg_rxdata: wb_dat_o <= {{(wb_dat_width - byte_width){1'b0}}, rx_byte};
          default:    wb_dat_o <= '0;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_wr && !cmd_valid) begin
      cmd_data <= wb_dat_i[cmd_width-1:0];
    end
    if (rx_if.done) begin
      rx_byte <= rx_if.data;
    end
  end

  // ====================
  // Receive flags
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_valid   <= 1'b0;
      parity_err <= 1'b0;
      frame_err  <= 1'b0;
      overrun    <= 1'b0;
    end else begin
      if (rx_if.done) begin
        rx_valid <= 1'b1;
      end else if (rxdata_rd) begin
        rx_valid <= 1'b0;
      end
      // Write 1 to clear, new events win
      if (status_wr && wb_dat_i[st_parity_err]) parity_err <= 1'b0;
      if (status_wr && wb_dat_i[st_frame_err]) frame_err <= 1'b0;
      if (status_wr && wb_dat_i[st_overrun]) overrun <= 1'b0;
      if (rx_if.done && rx_if.parity_err) parity_err <= 1'b1;
      if (rx_if.done && rx_if.frame_err) frame_err <= 1'b1;
      if (rx_if.done && rx_valid && !rxdata_rd) overrun <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* test/tb_uart_cmd_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_uart_cmd_bridge
  import uart_pkg::*;
();

  localparam int bus_timeout   = 25000;
  localparam int frame_timeout = 25000;
  localparam int poll_limit    = 4000;

  logic                    clk;
  logic                    rst_n;
  logic                    wb_cyc;
  logic                    wb_stb;
  logic                    wb_we;
  logic [wb_adr_width-1:0] wb_adr;
  logic [wb_dat_width-1:0] wb_dat_i;
  logic [wb_dat_width-1:0] wb_dat_o;
  logic                    wb_ack;
  logic                    tx_line;
  logic                    rx_line;
  logic                    drv_rx;
  logic                    loopback;
  logic                    b_acked;
  int                      errors;

  // Serial input comes back from tx or from the frame driver
  assign rx_line = loopback ? tx_line : drv_rx;

  uart_cmd_bridge uut (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack   (wb_ack),
    .tx       (tx_line),
    .rx       (rx_line)
  );

  always #5 clk = ~clk;

  // ====================
  // Bus rule checks
  // ====================
  ack_single_cycle: assert property (@(posedge clk) disable iff (!rst_n) wb_ack |=> !wb_ack)
    else begin
      errors++;
      $display("Wishbone ack stayed high for more than one cycle at %0t", $time);
    end

  ack_needs_stb: assert property (@(posedge clk) disable iff (!rst_n) wb_ack |-> wb_cyc && wb_stb)
    else begin
      errors++;
      $display("Wishbone ack was raised without an active strobe at %0t", $time);
    end

  task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] act);
    assert (act === exp) else begin
      errors++;
      $display("ERROR %0t %s: expected %h, got %h", $time, name, exp, act);
    end
  endtask

  // Parity bit that makes the count of ones over data and parity odd
  function automatic logic odd_parity_bit(input logic [7:0] data);
    int ones;
    ones = 0;
    for (int i = 0; i < 8; i++) begin
      ones += data[i];
    end
    return (ones % 2) == 0;
  endfunction

  // One access; stb drops one cycle after ack is seen
  task automatic bus_access(input logic we, input logic [wb_adr_width-1:0] adr,
                            input logic [15:0] wdata, output logic [15:0] rdata);
    int n;
    @(posedge clk);
    #1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_i = wdata;
    n = 0;
    do begin
      @(posedge clk);
      #1;
      n++;
    end while (wb_ack !== 1'b1 && n < bus_timeout);
    rdata = wb_dat_o;
    if (wb_ack !== 1'b1) begin
      errors++;
      $display("Timeout: no Wishbone ack for access to address %0d at %0t", adr, $time);
    end
    @(posedge clk);
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input logic [wb_adr_width-1:0] adr, input logic [15:0] data);
    logic [15:0] unused;
    bus_access(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(input logic [wb_adr_width-1:0] adr, output logic [15:0] data);
    bus_access(1'b0, adr, 16'h0000, data);
  endtask

  task automatic wait_rx_valid(output logic [15:0] st);
    int n;
    n  = 0;
    st = '0;
    while (st[st_rx_valid] !== 1'b1 && n < poll_limit) begin
      wb_read(reg_status, st);
      n++;
    end
    if (st[st_rx_valid] !== 1'b1) begin
      errors++;
      $display("Timeout: receiver never reported a byte at %0t", $time);
    end
  endtask

  // Decode one frame from tx, sampling each bit at its centre
  task automatic recv_frame(output logic [7:0] data);
    int n;
    n    = 0;
    data = '0;
    while (tx_line !== 1'b0 && n < frame_timeout) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (tx_line !== 1'b0) begin
      errors++;
      $display("Timeout: no start bit seen on tx at %0t", $time);
    end else begin
      repeat (half_bit) @(posedge clk);
      #1;
      check_value("tx start bit", 16'h0000, tx_line);
      for (int i = 0; i < byte_width; i++) begin
        repeat (clks_per_bit) @(posedge clk);
        #1;
        data[i] = tx_line;
      end
      repeat (clks_per_bit) @(posedge clk);
      #1;
      check_value("tx parity bit", odd_parity_bit(data), tx_line);
      repeat (clks_per_bit) @(posedge clk);
      #1;
      check_value("tx stop bit", 16'h0001, tx_line);
    end
  endtask

  task automatic send_frame(input logic [7:0] data, input logic bad_parity, input logic bad_stop);
    logic [10:0] bits;
    bits = {~bad_stop, odd_parity_bit(data) ^ bad_parity, data, 1'b0};
    @(posedge clk);
    #1;
    for (int i = 0; i < 11; i++) begin
      drv_rx = bits[i];
      repeat (clks_per_bit) @(posedge clk);
      #1;
    end
    drv_rx = 1'b1;
  endtask

  // ====================
  // Test sequence
  // ====================
  initial begin
    logic [15:0] cmd_a;
    logic [15:0] cmd_b;
    logic [15:0] st;
    logic [15:0] rd;
    logic [7:0]  f0;
    logic [7:0]  f1;
    logic [7:0]  f2;
    logic [7:0]  f3;
    void'($urandom(32'h105a));
    errors   = 0;
    clk      = 1'b0;
    rst_n    = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_i = '0;
    drv_rx   = 1'b1;
    loopback = 1'b0;
    b_acked  = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Reset state
    check_value("tx", 16'h0001, tx_line);
    check_value("wb_ack", 16'h0000, wb_ack);
    wb_read(reg_status, st);
    check_value("status after reset", 16'h0000, st);

    // Command goes out high byte first
    cmd_a = 16'($urandom());
    fork
      begin
        wb_write(reg_cmd, cmd_a);
        wb_read(reg_status, st);
        check_value("status while sending", 16'h0001, st);
      end
      begin
        recv_frame(f0);
        recv_frame(f1);
      end
    join
    check_value("tx high byte", cmd_a[15:8], f0);
    check_value("tx low byte", cmd_a[7:0], f1);
    repeat (clks_per_bit) @(posedge clk);
    wb_read(reg_status, st);
    check_value("status after send", 16'h0000, st);

    // Loopback
    loopback = 1'b1;
    cmd_a    = 16'($urandom());
    wb_write(reg_cmd, cmd_a);
    wait_rx_valid(st);
    check_value("status high byte in", 16'h0002, st & 16'hfffe);
    wb_read(reg_rxdata, rd);
    check_value("rxdata high byte", cmd_a[15:8], rd);
    wb_read(reg_status, st);
    check_value("status after read", 16'h0000, st & 16'hfffe);
    wait_rx_valid(st);
    check_value("status low byte in", 16'h0002, st & 16'hfffe);
    wb_read(reg_rxdata, rd);
    check_value("rxdata low byte", cmd_a[7:0], rd);
    wb_read(reg_status, st);
    check_value("status after read", 16'h0000, st & 16'hfffe);
    loopback = 1'b0;
    repeat (clks_per_bit) @(posedge clk);

    // Back-pressure on a second command
    cmd_a = 16'($urandom());
    cmd_b = 16'($urandom());
    wb_write(reg_cmd, cmd_a);
    fork
      begin
        wb_write(reg_cmd, cmd_b);
        b_acked = 1'b1;
      end
      begin
        recv_frame(f0);
        recv_frame(f1);
        assert (!b_acked) else begin
          errors++;
          $display("Second command was acknowledged before the first one ended at %0t", $time);
        end
        recv_frame(f2);
        recv_frame(f3);
      end
    join
    check_value("tx first high byte", cmd_a[15:8], f0);
    check_value("tx first low byte", cmd_a[7:0], f1);
    check_value("tx second high byte", cmd_b[15:8], f2);
    check_value("tx second low byte", cmd_b[7:0], f3);
    repeat (clks_per_bit) @(posedge clk);

    // Parity and framing errors
    f0 = 8'($urandom());
    send_frame(f0, 1'b1, 1'b0);
    wait_rx_valid(st);
    check_value("status parity error", 16'h0006, st);
    wb_read(reg_rxdata, rd);
    check_value("rxdata bad parity", f0, rd);
    wb_write(reg_status, 16'h0004);
    send_frame(f0, 1'b0, 1'b1);
    wait_rx_valid(st);
    check_value("status frame error", 16'h000a, st);
    wb_read(reg_rxdata, rd);
    wb_write(reg_status, 16'h000c);
    wb_read(reg_status, st);
    check_value("status after clear", 16'h0000, st);

    // Overrun
    f0 = 8'($urandom());
    f1 = ~f0;
    send_frame(f0, 1'b0, 1'b0);
    send_frame(f1, 1'b0, 1'b0);
    wait_rx_valid(st);
    check_value("status overrun", 16'h0012, st);
    wb_read(reg_rxdata, rd);
    check_value("rxdata after overrun", f1, rd);
    wb_write(reg_status, 16'h0010);
    wb_read(reg_status, st);
    check_value("status overrun cleared", 16'h0000, st);

    $display("Run finished with %0d errors", errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* uart_cmd_bridge.f */
rtl/uart_pkg.sv
rtl/uart_rx_if.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_wb_regs.sv
rtl/uart_cmd_bridge.sv
test/tb_uart_cmd_bridge.sv
